//--- verilog/dcache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache package
// widths, address and line layouts, processor and memory bus
// structs and the controller state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dcache_pkg;

   // 8 sets of two-word blocks
   localparam int WORD_W   = 32;
   localparam int TAG_W    = 26;
   localparam int IDX_W    = 3;
   localparam int NUM_SETS = 8;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [TAG_W-1:0]  tag_t;
   typedef logic [IDX_W-1:0]  idx_t;

   // byte address as seen by the cache
   typedef struct packed {
      tag_t       tag;
      idx_t       idx;
      logic       blk;
      logic [1:0] byt;
   } daddr_t;

   // one cache block with its state bits
   typedef struct packed {
      logic            valid;
      logic            dirty;
      tag_t            tag;
      word_t [1:0]     data;
   } line_t;

   // whole-line write into one way
   typedef struct packed {
      logic  en;
      idx_t  idx;
      line_t line;
   } way_wr_t;

   // processor side
   typedef struct packed {
      logic   ren;
      logic   wen;
      logic   halt;
      daddr_t addr;
      word_t  store;
   } cpu_req_t;

   typedef struct packed {
      logic  hit;
      logic  flushed;
      word_t load;
   } cpu_rsp_t;

   // memory side moves one word per transfer
   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } mem_req_t;

   typedef enum logic [2:0] {
      IDLE,
      WB,
      FILL,
      FLUSH_SCAN,
      FLUSH_WB,
      COUNT_WR,
      DONE
   } ctrl_state_t;

endpackage

//--- verilog/cache_way.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one way of the two-way data cache
// holds valid, dirty, tag and two data words per set and
// does its own tag compare for the set being looked up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cache_way (
   input  logic                CLK,
   input  logic                nRST,
   input  dcache_pkg::idx_t    lookup_idx,
   input  dcache_pkg::tag_t    lookup_tag,
   input  dcache_pkg::way_wr_t wr,
   output dcache_pkg::line_t   line,
   output logic                hit
);
   import dcache_pkg::*;

   // state bits per set
   logic [NUM_SETS-1:0] valid_q;
   logic [NUM_SETS-1:0] dirty_q;

   // tag and data storage
   tag_t                tag_q  [NUM_SETS];
   word_t               data_q [NUM_SETS][2];

   // valid and dirty come up cleared
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         valid_q <= '0;
         dirty_q <= '0;
      end
      else if (wr.en) begin
         valid_q[wr.idx] <= wr.line.valid;
         dirty_q[wr.idx] <= wr.line.dirty;
      end
   end

   // tag and both words are rewritten together
   always_ff @(posedge CLK) begin
      if (wr.en) begin
         tag_q[wr.idx]     <= wr.line.tag;
         data_q[wr.idx][0] <= wr.line.data[0];
         data_q[wr.idx][1] <= wr.line.data[1];
      end
   end

   // combinational read of the addressed set
   always_comb begin
      line.valid   = valid_q[lookup_idx];
      line.dirty   = dirty_q[lookup_idx];
      line.tag     = tag_q[lookup_idx];
      line.data[0] = data_q[lookup_idx][0];
      line.data[1] = data_q[lookup_idx][1];
   end

   // invalid lines never match
   assign hit = line.valid && (line.tag == lookup_tag);

endmodule

//--- verilog/dcache_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache controller
// merges way hits, keeps LRU bits and the hit count, and runs
// victim write-back, block fill and the halt flush sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dcache_ctrl #(
   parameter dcache_pkg::word_t HIT_COUNT_ADDR
) (
   input  logic                 CLK,
   input  logic                 nRST,
   input  dcache_pkg::cpu_req_t cpu_req,
   output dcache_pkg::cpu_rsp_t cpu_rsp,
   output dcache_pkg::idx_t     lookup_idx,
   output dcache_pkg::tag_t     lookup_tag,
   input  dcache_pkg::line_t    line0,
   input  logic                 hit0,
   input  dcache_pkg::line_t    line1,
   input  logic                 hit1,
   output dcache_pkg::way_wr_t  wr0,
   output dcache_pkg::way_wr_t  wr1,
   output dcache_pkg::mem_req_t mem_req,
   input  logic                 dwait,
   input  dcache_pkg::word_t    dload
);
   import dcache_pkg::*;

   // control state
   ctrl_state_t         state_q, state_n;
   logic                word_q, word_n;
   logic                victim_q, victim_n;
   logic [IDX_W:0]      flush_cnt_q, flush_cnt_n;
   logic [NUM_SETS-1:0] lru_q, lru_n;
   word_t               hit_count_q, hit_count_n;
   logic                miss_pending_q, miss_pending_n;

   // first fill word waits here for the second
   word_t               fill_buf_q;

   daddr_t              addr;
   logic                req;
   logic                hit;
   logic                hit_way;
   logic                victim_sel;
   logic                victim_way;
   logic                flush_way;
   logic                flush_last;
   line_t               hit_line;
   line_t               victim_line;
   line_t               flush_line;
   way_wr_t             wr_n;
   logic                wr_way;

   assign addr = cpu_req.addr;
   assign req  = cpu_req.ren || cpu_req.wen;

   // flush counter is {set, way} with the way bit fastest
   assign flush_way  = flush_cnt_q[0];
   assign flush_last = &flush_cnt_q;

   // flush walks its own index and otherwise follows the processor
   assign lookup_idx = (state_q == FLUSH_SCAN || state_q == FLUSH_WB) ?
                       flush_cnt_q[IDX_W:1] : addr.idx;
   assign lookup_tag = addr.tag;

   // hits only count while idle
   assign hit      = (state_q == IDLE) && req && (hit0 || hit1);
   assign hit_way  = hit1;
   assign hit_line = hit_way ? line1 : line0;

   // first empty way from way 0 up or else the LRU choice
   assign victim_sel  = !line0.valid ? 1'b0 :
                        !line1.valid ? 1'b1 : lru_q[addr.idx];
   // held victim once the miss sequence has started
   assign victim_way  = (state_q == IDLE) ? victim_sel : victim_q;
   assign victim_line = victim_way ? line1 : line0;
   assign flush_line  = flush_way ? line1 : line0;

   assign cpu_rsp.hit     = hit;
   assign cpu_rsp.flushed = (state_q == DONE);
   assign cpu_rsp.load    = hit_line.data[addr.blk];

   always_comb begin
      state_n        = state_q;
      word_n         = word_q;
      victim_n       = victim_q;
      flush_cnt_n    = flush_cnt_q;
      lru_n          = lru_q;
      hit_count_n    = hit_count_q;
      miss_pending_n = miss_pending_q;
      mem_req        = '0;
      wr_n           = '0;
      wr_n.idx       = lookup_idx;
      wr_way         = 1'b0;

      case (state_q)
         IDLE: begin
            if (hit) begin
               // point LRU at the other way
               lru_n[addr.idx] = ~hit_way;
               miss_pending_n  = 1'b0;
               // hits that close a miss are not counted
               if (!miss_pending_q) begin
                  hit_count_n = hit_count_q + 1'b1;
               end
               if (cpu_req.wen) begin
                  wr_n.en                  = 1'b1;
                  wr_way                   = hit_way;
                  wr_n.line                = hit_line;
                  wr_n.line.dirty          = 1'b1;
                  wr_n.line.data[addr.blk] = cpu_req.store;
               end
            end
            else if (req) begin
               miss_pending_n = 1'b1;
               victim_n       = victim_sel;
               word_n         = 1'b0;
               state_n        = victim_line.dirty ? WB : FILL;
            end
            else if (cpu_req.halt) begin
               flush_cnt_n = '0;
               state_n     = FLUSH_SCAN;
            end
         end

         WB: begin
            // old block goes back at its own address
            mem_req.wen   = 1'b1;
            mem_req.addr  = {victim_line.tag, addr.idx, word_q, 2'b00};
            mem_req.store = victim_line.data[word_q];
            if (!dwait) begin
               word_n = ~word_q;
               if (word_q) begin
                  state_n = FILL;
               end
            end
         end

         FILL: begin
            mem_req.ren  = 1'b1;
            mem_req.addr = {addr.tag, addr.idx, word_q, 2'b00};
            if (!dwait) begin
               word_n = ~word_q;
               if (word_q) begin
                  // installed clean so the request then hits in IDLE
                  wr_n.en           = 1'b1;
                  wr_way            = victim_q;
                  wr_n.line.valid   = 1'b1;
                  wr_n.line.dirty   = 1'b0;
                  wr_n.line.tag     = addr.tag;
                  wr_n.line.data[0] = fill_buf_q;
                  wr_n.line.data[1] = dload;
                  state_n           = IDLE;
               end
            end
         end

         FLUSH_SCAN: begin
            if (flush_line.dirty) begin
               word_n  = 1'b0;
               state_n = FLUSH_WB;
            end
            else if (flush_last) begin
               state_n = COUNT_WR;
            end
            else begin
               flush_cnt_n = flush_cnt_q + 1'b1;
            end
         end

         FLUSH_WB: begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = {flush_line.tag, lookup_idx, word_q, 2'b00};
            mem_req.store = flush_line.data[word_q];
            if (!dwait) begin
               word_n = ~word_q;
               if (word_q) begin
                  // block now matches memory
                  wr_n.en         = 1'b1;
                  wr_way          = flush_way;
                  wr_n.line       = flush_line;
                  wr_n.line.dirty = 1'b0;
                  flush_cnt_n     = flush_cnt_q + 1'b1;
                  state_n         = flush_last ? COUNT_WR : FLUSH_SCAN;
               end
            end
         end

         COUNT_WR: begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = HIT_COUNT_ADDR;
            mem_req.store = hit_count_q;
            if (!dwait) begin
               state_n = DONE;
            end
         end

         // flushed held until reset
         DONE: begin
            state_n = DONE;
         end

         default: begin
            state_n = IDLE;
         end
      endcase
   end

   // steer the single write to the chosen way
   always_comb begin
      wr0    = wr_n;
      wr1    = wr_n;
      wr0.en = wr_n.en && !wr_way;
      wr1.en = wr_n.en && wr_way;
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state_q        <= IDLE;
         word_q         <= 1'b0;
         victim_q       <= 1'b0;
         flush_cnt_q    <= '0;
         lru_q          <= '0;
         hit_count_q    <= '0;
         miss_pending_q <= 1'b0;
      end
      else begin
         state_q        <= state_n;
         word_q         <= word_n;
         victim_q       <= victim_n;
         flush_cnt_q    <= flush_cnt_n;
         lru_q          <= lru_n;
         hit_count_q    <= hit_count_n;
         miss_pending_q <= miss_pending_n;
      end
   end

   // capture word 0 of the fill
   always_ff @(posedge CLK) begin
      if (state_q == FILL && !dwait && !word_q) begin
         fill_buf_q <= dload;
      end
   end

endmodule

//--- verilog/dcache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back data cache, two-way set associative
// two ways looked up in parallel, one controller on the memory bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dcache #(
   parameter dcache_pkg::word_t HIT_COUNT_ADDR = 32'h3100
) (
   input  logic                 CLK,
   input  logic                 nRST,
   input  dcache_pkg::cpu_req_t cpu_req,
   output dcache_pkg::cpu_rsp_t cpu_rsp,
   output dcache_pkg::mem_req_t mem_req,
   input  logic                 dwait,
   input  dcache_pkg::word_t    dload
);
   import dcache_pkg::*;

   // shared lookup address
   idx_t    lookup_idx;
   tag_t    lookup_tag;

   // per way results and writes
   line_t   line0, line1;
   logic    hit0, hit1;
   way_wr_t wr0, wr1;

   cache_way way0_i (
      .CLK        (CLK),
      .nRST       (nRST),
      .lookup_idx (lookup_idx),
      .lookup_tag (lookup_tag),
      .wr         (wr0),
      .line       (line0),
      .hit        (hit0)
   );

   cache_way way1_i (
      .CLK        (CLK),
      .nRST       (nRST),
      .lookup_idx (lookup_idx),
      .lookup_tag (lookup_tag),
      .wr         (wr1),
      .line       (line1),
      .hit        (hit1)
   );

   dcache_ctrl #(
      .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
   ) ctrl_i (
      .CLK        (CLK),
      .nRST       (nRST),
      .cpu_req    (cpu_req),
      .cpu_rsp    (cpu_rsp),
      .lookup_idx (lookup_idx),
      .lookup_tag (lookup_tag),
      .line0      (line0),
      .hit0       (hit0),
      .line1      (line1),
      .hit1       (hit1),
      .wr0        (wr0),
      .wr1        (wr1),
      .mem_req    (mem_req),
      .dwait      (dwait),
      .dload      (dload)
   );

endmodule

//--- sim/dcache_tests.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests for the data cache
// reset state, miss and hit, store hit, LRU victim, dirty
// write-back and the halt flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_reset_state();
   @(negedge CLK);
   #1;
   if (cpu_rsp.hit !== 1'b0) report_mismatch("cpu_rsp.hit", 0, cpu_rsp.hit);
   if (cpu_rsp.flushed !== 1'b0) report_mismatch("cpu_rsp.flushed", 0, cpu_rsp.flushed);
   if (mem_req.ren !== 1'b0) report_mismatch("mem_req.ren", 0, mem_req.ren);
   if (mem_req.wen !== 1'b0) report_mismatch("mem_req.wen", 0, mem_req.wen);
   finish_test("reset state");
endtask

task automatic read_miss_then_hit();
   word_t a0, a1, load;
   logic  first;
   a0 = make_addr(26'd10, 3'd1, 1'b0);
   a1 = make_addr(26'd10, 3'd1, 1'b1);
   access(1'b0, a0, '0, load, first);
   if (first) report_problem("cold read hit in its first cycle");
   if (load !== expect_word(a0)) report_mismatch("cpu_rsp.load", expect_word(a0), load);
   // other word came in with the fill
   access(1'b0, a1, '0, load, first);
   if (!first) report_problem("second word of a filled block did not hit at once");
   if (load !== expect_word(a1)) report_mismatch("cpu_rsp.load", expect_word(a1), load);
   finish_test("read miss then hit");
endtask

task automatic store_hit_keeps_neighbor();
   word_t a0, a1, val, load;
   logic  first;
   int    base;
   a0   = make_addr(26'd10, 3'd1, 1'b0);
   a1   = make_addr(26'd10, 3'd1, 1'b1);
   val  = $random(seed);
   base = log_addr.size();
   access(1'b1, a0, val, load, first);
   if (!first) report_problem("store to a resident block did not hit at once");
   access(1'b0, a0, '0, load, first);
   if (load !== val) report_mismatch("cpu_rsp.load", val, load);
   access(1'b0, a1, '0, load, first);
   if (load !== expect_word(a1)) report_mismatch("cpu_rsp.load", expect_word(a1), load);
   // write-back cache sends nothing out
   if (log_addr.size() != base) report_mismatch("memory write count", base, log_addr.size());
   finish_test("store hit");
endtask

task automatic lru_picks_victim();
   word_t a, b, c, load;
   logic  first;
   a = make_addr(26'd20, 3'd2, 1'b0);
   b = make_addr(26'd21, 3'd2, 1'b0);
   c = make_addr(26'd22, 3'd2, 1'b0);
   access(1'b0, a, '0, load, first);
   access(1'b0, b, '0, load, first);
   // B becomes least recently used
   access(1'b0, a, '0, load, first);
   if (!first) report_problem("reread of A did not hit at once");
   access(1'b0, c, '0, load, first);
   if (load !== expect_word(c)) report_mismatch("cpu_rsp.load", expect_word(c), load);
   access(1'b0, a, '0, load, first);
   if (!first) report_problem("A was evicted instead of B");
   access(1'b0, b, '0, load, first);
   if (first) report_problem("B still resident after C was filled");
   if (load !== expect_word(b)) report_mismatch("cpu_rsp.load", expect_word(b), load);
   finish_test("LRU victim");
endtask

task automatic dirty_victim_writeback();
   word_t addr [4];
   word_t c, load;
   logic  first;
   int    base;
   addr[0] = make_addr(26'd30, 3'd3, 1'b0);
   addr[1] = make_addr(26'd30, 3'd3, 1'b1);
   addr[2] = make_addr(26'd31, 3'd3, 1'b0);
   addr[3] = make_addr(26'd31, 3'd3, 1'b1);
   c       = make_addr(26'd32, 3'd3, 1'b0);
   for (int i = 0; i < 4; i++) begin
      access(1'b1, addr[i], $random(seed), load, first);
   end
   base = log_addr.size();
   // A is least recently used so it goes back
   access(1'b0, c, '0, load, first);
   if (load !== expect_word(c)) report_mismatch("cpu_rsp.load", expect_word(c), load);
   if (log_addr.size() != base + 2) begin
      report_mismatch("memory write count", base + 2, log_addr.size());
   end
   else begin
      for (int i = 0; i < 2; i++) begin
         if (log_addr[base+i] !== addr[i]) begin
            report_mismatch("mem_req.addr", addr[i], log_addr[base+i]);
         end
         if (log_data[base+i] !== ref_mem[addr[i]]) begin
            report_mismatch("mem_req.store", ref_mem[addr[i]], log_data[base+i]);
         end
      end
   end
   finish_test("dirty write-back");
endtask

task automatic halt_flushes_cache();
   word_t exp_addr [$];
   word_t load;
   logic  first;
   int    base;
   int    cycles;
   reset_dut();
   access(1'b1, make_addr(26'd40, 3'd4, 1'b0), $random(seed), load, first);
   access(1'b1, make_addr(26'd40, 3'd4, 1'b1), $random(seed), load, first);
   access(1'b1, make_addr(26'd41, 3'd4, 1'b1), $random(seed), load, first);
   access(1'b1, make_addr(26'd50, 3'd5, 1'b0), $random(seed), load, first);
   access(1'b0, make_addr(26'd60, 3'd6, 1'b0), '0, load, first);
   access(1'b0, make_addr(26'd50, 3'd5, 1'b1), '0, load, first);
   // dirty blocks in set then way order with each word once
   exp_addr = {make_addr(26'd40, 3'd4, 1'b0), make_addr(26'd40, 3'd4, 1'b1),
               make_addr(26'd41, 3'd4, 1'b0), make_addr(26'd41, 3'd4, 1'b1),
               make_addr(26'd50, 3'd5, 1'b0), make_addr(26'd50, 3'd5, 1'b1)};
   base   = log_addr.size();
   cycles = 0;
   @(negedge CLK);
   cpu_req.halt = 1'b1;
   #1;
   while (!cpu_rsp.flushed && cycles < ACCESS_LIMIT) begin
      @(negedge CLK);
      #1;
      cycles++;
   end
   if (!cpu_rsp.flushed) report_problem("flushed never rose after halt");
   if (log_addr.size() != base + 7) begin
      report_mismatch("memory write count", base + 7, log_addr.size());
   end
   else begin
      foreach (exp_addr[i]) begin
         if (log_addr[base+i] !== exp_addr[i]) begin
            report_mismatch("mem_req.addr", exp_addr[i], log_addr[base+i]);
         end
         if (mem_word(exp_addr[i]) !== expect_word(exp_addr[i])) begin
            report_mismatch("memory word", expect_word(exp_addr[i]), mem_word(exp_addr[i]));
         end
      end
      if (log_addr[base+6] !== HIT_COUNT_ADDR) begin
         report_mismatch("mem_req.addr", HIT_COUNT_ADDR, log_addr[base+6]);
      end
      if (log_data[base+6] !== word_t'(hit_cnt)) begin
         report_mismatch("hit count word", hit_cnt, log_data[base+6]);
      end
   end
   // flushed holds
   repeat (4) begin
      @(negedge CLK);
      #1;
      if (cpu_rsp.flushed !== 1'b1) report_mismatch("cpu_rsp.flushed", 1, cpu_rsp.flushed);
   end
   finish_test("halt flush");
endtask

//--- sim/dcache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache testbench
// clock, reset, word memory with random wait states, watchdog,
// processor access helper and run summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dcache_tb;
   import dcache_pkg::*;

   localparam int    CLK_PERIOD     = 8;
   localparam int    SEED           = 32'hfa00_6555;
   localparam int    MAX_WAIT       = 3;
   localparam int    NUM_TESTS      = 6;
   localparam int    ACCESS_LIMIT   = 100;
   localparam word_t HIT_COUNT_ADDR = 32'h3100;

   logic     CLK;
   logic     nRST;
   cpu_req_t cpu_req;
   cpu_rsp_t cpu_rsp;
   mem_req_t mem_req;
   logic     dwait;
   word_t    dload;

   // memory model contents and write log
   word_t    mem [word_t];
   word_t    log_addr [$];
   word_t    log_data [$];
   int       seed;
   int       wait_left;
   bit       active;
   bit       done_pending;

   // values the processor should read back
   word_t    ref_mem [word_t];

   int       errors;
   int       test_errs;
   int       tests_run;
   int       tests_failed;
   int       hit_cnt;

   dcache #(
      .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
   ) dut_i (
      .CLK     (CLK),
      .nRST    (nRST),
      .cpu_req (cpu_req),
      .cpu_rsp (cpu_rsp),
      .mem_req (mem_req),
      .dwait   (dwait),
      .dload   (dload)
   );

   initial begin
      CLK = 1'b0;
   end
   always #(CLK_PERIOD / 2) CLK = ~CLK;

   // every address bit shows up in the preset value
   function automatic word_t preset_word(word_t a);
      return {a[15:0], a[31:16]} ^ (a << 5) ^ 32'h6b2d_91e7;
   endfunction

   function automatic word_t mem_word(word_t a);
      return mem.exists(a) ? mem[a] : preset_word(a);
   endfunction

   function automatic word_t expect_word(word_t a);
      return ref_mem.exists(a) ? ref_mem[a] : preset_word(a);
   endfunction

   function automatic word_t make_addr(tag_t tag, idx_t idx, logic blk);
      return {tag, idx, blk, 2'b00};
   endfunction

   // memory model making all decisions on the falling edge
   always @(negedge CLK) begin
      // transfer finished at the last rising edge
      if (done_pending) begin
         active       = 1'b0;
         done_pending = 1'b0;
      end
      if (!active && (mem_req.ren || mem_req.wen)) begin
         active    = 1'b1;
         wait_left = $unsigned($random(seed)) % (MAX_WAIT + 1);
      end
      else if (active && wait_left > 0) begin
         wait_left = wait_left - 1;
      end
      dwait = active && (wait_left != 0);
      dload = mem_word(mem_req.addr);
      // dwait low now so the next rising edge completes it
      if (active && wait_left == 0) begin
         done_pending = 1'b1;
         if (mem_req.wen) begin
            mem[mem_req.addr] = mem_req.store;
            log_addr.push_back(mem_req.addr);
            log_data.push_back(mem_req.store);
         end
      end
   end

   task automatic report_mismatch(string sig, word_t exp, word_t act);
      $display("FAIL at %0t: %s expected %h, got %h", $time, sig, exp, act);
      errors++;
      test_errs++;
   endtask

   task automatic report_problem(string msg);
      $display("ERROR at %0t: %s", $time, msg);
      errors++;
      test_errs++;
   endtask

   task automatic finish_test(string name);
      tests_run++;
      if (test_errs != 0) begin
         tests_failed++;
      end
      $display("test %-26s %s (%0d errors)", name,
               (test_errs == 0) ? "passed" : "with errors", test_errs);
      test_errs = 0;
   endtask

   // two reset cycles and expected data restarts from memory
   task automatic reset_dut();
      nRST = 1'b0;
      repeat (2) @(negedge CLK);
      nRST         = 1'b1;
      hit_cnt      = 0;
      active       = 1'b0;
      done_pending = 1'b0;
      ref_mem      = mem;
   endtask

   // one load or store held until hit
   task automatic access(input logic wr, input word_t a, input word_t data,
                         output word_t load, output logic first);
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      first  = 1'b0;
      load   = '0;
      @(negedge CLK);
      cpu_req.ren   = !wr;
      cpu_req.wen   = wr;
      cpu_req.addr  = a;
      cpu_req.store = data;
      while (!done && cycles < ACCESS_LIMIT) begin
         #1;
         if (cpu_rsp.hit) begin
            done  = 1'b1;
            first = (cycles == 0);
            load  = cpu_rsp.load;
         end
         else begin
            cycles++;
            @(negedge CLK);
         end
      end
      if (!done) begin
         report_problem($sformatf("no hit for address %h in %0d cycles", a, ACCESS_LIMIT));
      end
      else begin
         // only first-cycle hits are counted by the cache
         if (first) begin
            hit_cnt++;
         end
         if (wr) begin
            ref_mem[a] = data;
         end
      end
      // hold across the completing edge and drop after
      @(negedge CLK);
      cpu_req.ren = 1'b0;
      cpu_req.wen = 1'b0;
   endtask

   `include "dcache_tests.svh"

   initial begin
      cpu_req      = '0;
      dwait        = 1'b0;
      dload        = '0;
      nRST         = 1'b0;
      seed         = SEED;
      errors       = 0;
      test_errs    = 0;
      tests_run    = 0;
      tests_failed = 0;
      reset_dut();
      check_reset_state();
      read_miss_then_hit();
      store_hit_keeps_neighbor();
      lru_picks_victim();
      dirty_victim_writeback();
      halt_flushes_cache();
      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end
      else begin
         $display("Something failed");
      end
      $finish;
   end

   // watchdog with a fixed budget per test
   initial begin
      #(NUM_TESTS * 2000);
      $display("timeout after %0d time units, the run did not complete", NUM_TESTS * 2000);
      $display("Something failed");
      $finish;
   end

endmodule

//--- compile.f
+incdir+sim
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
sim/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - verilog/dcache_pkg.sv
      - verilog/cache_way.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/dcache_tb.sv
